// ==== design/m68k_glue_defines.svh ====
`ifndef M68K_GLUE_DEFINES_SVH
`define M68K_GLUE_DEFINES_SVH

// ============================================================
// Bus widths
// ============================================================
`define ADDR_W          23      // CPU address bits 23..1
`define DATA_W          16      // CPU and memory data bus
`define SPI_ADDR_W      32      // Loader byte address

// ============================================================
// Timing constants
// ============================================================
`define PWRUP_BITS      16      // Power-up stretch, 2^16-1 cycles
`define BAUD_TOP        162     // 25 MHz / 163 = 16 x 9600
`define BAUD_HIGH_FROM  81      // Baud clock high above this count

// ============================================================
// Address codes
// ============================================================
`define PERIPH_PAGE     6'b011000  // CPU 0x600000..0x63ffff
`define CTRL_PAGE       8'hFF      // Loader top byte, control register
`define MEM_PAGE        8'h00      // Loader top byte, external memory

`define CTRL_RESET_VAL  8'h04   // Halted, CPU owns memory

`endif

// ==== design/bus_pkg.sv ====
`default_nettype none

// CPU side bus decoding types
package bus_pkg;

  // Source of the data returned to the CPU on a read
  typedef enum logic [1:0]
  {
    RD_MEM  = 2'd0,  // External memory, default
    RD_ACIA = 2'd1,  // UART byte
    RD_KBD  = 2'd2   // One byte of the key matrix
  } rd_source_t;

endpackage

`default_nettype wire

// ==== design/loader_pkg.sv ====
`default_nettype none

// SPI loader types
package loader_pkg;

  // Control fields, bit 0 at the bottom
  typedef struct packed
  {
    logic [4:0] spare;            // Unused, kept as written
    logic       halt;             // Bit 2, CPU halted
    logic       loader_owns_mem;  // Bit 1, memory port to loader
    logic       cpu_reset;        // Bit 0, hold CPU in reset
  } cpu_ctrl_fields_t;

  // Same byte seen as raw loader data or as fields
  typedef union packed
  {
    logic [7:0]       raw;  // Loader writes whole byte
    cpu_ctrl_fields_t f;    // Decoded by bus and memory logic
  } cpu_ctrl_t;

endpackage

`default_nettype wire

// ==== design/timing_gen.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "m68k_glue_defines.svh"

module timing_gen
(
  input  wire  clk_cpu,
  input  wire  i_reset,
  output logic o_phi1,      // CPU phase 1 enable
  output logic o_phi2,      // CPU phase 2 enable
  output logic o_baud_clk,  // x16 UART clock
  output logic o_pwr_up     // High until counter saturates
);

  localparam int BAUD_W = $clog2(`BAUD_TOP + 1);
  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`BAUD_TOP);
  localparam logic [BAUD_W-1:0] BAUD_HIGH = BAUD_W'(`BAUD_HIGH_FROM);

  logic [BAUD_W-1:0]      baud_cnt;
  logic [`PWRUP_BITS-1:0] pwr_cnt;

  // ============================================================
  // Phase enables, full speed
  // ============================================================
  always_ff @(posedge clk_cpu)
  begin
    if (i_reset)
    begin
      o_phi1 <= 1'b0;
      o_phi2 <= 1'b0;
    end
    else
    begin
      o_phi1 <= ~o_phi1;  // Toggle every cycle
      o_phi2 <= o_phi1;   // One cycle behind phi1
    end
  end

  // Baud divider, period BAUD_TOP+1
  always_ff @(posedge clk_cpu)
  begin
    if (i_reset)
    begin
      baud_cnt   <= '0;
      o_baud_clk <= 1'b0;
    end
    else
    begin
      baud_cnt   <= (baud_cnt == BAUD_LAST) ? '0 : baud_cnt + 1'b1;
      o_baud_clk <= (baud_cnt > BAUD_HIGH);  // Upper half of the count
    end
  end

  // Power-up stretch, stops at all ones
  always_ff @(posedge clk_cpu)
  begin
    if (i_reset)
      pwr_cnt <= '0;
    else if (!(&pwr_cnt))
      pwr_cnt <= pwr_cnt + 1'b1;
  end

  assign o_pwr_up = ~(&pwr_cnt);

endmodule

`default_nettype wire

// ==== design/bus_control.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "m68k_glue_defines.svh"

module bus_control
(
  input  wire [`ADDR_W:1]          i_cpu_addr,
  input  wire                      i_cpu_as_n,
  input  wire                      i_cpu_vma_n,
  input  wire                      i_btn_reset_n,    // Low while pressed
  input  wire                      i_pwr_up,
  input  wire loader_pkg::cpu_ctrl_t i_ctrl,
  output logic                     o_vpa_n,
  output logic                     o_acia_cs,
  output logic                     o_kbd_cs,
  output bus_pkg::rd_source_t      o_rd_src,
  output logic                     o_cpu_halt_n,
  output logic                     o_cpu_ext_reset,
  output logic                     o_cpu_pwr_up
);

  import bus_pkg::*;

  logic periph_page;  // Address in the peripheral window

  // ============================================================
  // Peripheral decode
  // ============================================================
  assign periph_page = (i_cpu_addr[23:18] == `PERIPH_PAGE);

  // Valid peripheral address, only with AS asserted
  assign o_vpa_n = ~periph_page | i_cpu_as_n;

  // 6800-style cycle selects, qualified by VMA
  assign o_acia_cs = ~i_cpu_vma_n && (i_cpu_addr[3:2] == 2'd0);  // 0x0..0x3
  assign o_kbd_cs  = ~i_cpu_vma_n && (i_cpu_addr[3:1] == 3'd3);  // 0x6..0x7

  // Read source, UART wins over keyboard
  always_comb
  begin
    if (o_acia_cs)
      o_rd_src = RD_ACIA;
    else if (o_kbd_cs)
      o_rd_src = RD_KBD;
    else
      o_rd_src = RD_MEM;
  end

  // ============================================================
  // CPU reset and halt
  // ============================================================
  // Pressed button, power-up stretch or loader request
  assign o_cpu_ext_reset = ~i_btn_reset_n | i_pwr_up | i_ctrl.f.cpu_reset;

  assign o_cpu_halt_n = ~i_ctrl.f.halt;  // Halted until loader releases
  assign o_cpu_pwr_up = i_pwr_up;

endmodule

`default_nettype wire

// ==== design/read_data_mux.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "m68k_glue_defines.svh"

module read_data_mux
(
  input  wire bus_pkg::rd_source_t i_rd_src,
  input  wire [`ADDR_W:1]          i_cpu_addr,
  input  wire [7:0]                i_acia_dout,
  input  wire [63:0]               i_kbd_matrix,
  input  wire [`DATA_W-1:0]        i_mem_dout,
  output logic [`DATA_W-1:0]       o_cpu_din
);

  import bus_pkg::*;

  logic [5:0] kbd_lsb;   // Bit offset of the matrix byte
  logic [7:0] kbd_byte;

  // Byte N of the matrix, N from address bits 6..4
  assign kbd_lsb  = {i_cpu_addr[6:4], 3'b000};
  assign kbd_byte = i_kbd_matrix[kbd_lsb +: 8];

  always_comb
  begin
    case (i_rd_src)
      RD_ACIA: o_cpu_din = {8'd0, i_acia_dout};  // Low lane only
      RD_KBD:  o_cpu_din = {8'd0, kbd_byte};
      default: o_cpu_din = i_mem_dout;           // Memory pass-through
    endcase
  end

endmodule

`default_nettype wire

// ==== design/loader_regs.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "m68k_glue_defines.svh"

module loader_regs
(
  input  wire                        clk_cpu,
  input  wire                        i_reset,
  input  wire                        i_spi_wr,      // Level, one or more cycles
  input  wire                        i_spi_rd,
  input  wire [`SPI_ADDR_W-1:0]      i_spi_addr,
  input  wire [7:0]                  i_spi_data,
  input  wire [`DATA_W-1:0]          i_mem_dout,
  output loader_pkg::cpu_ctrl_t      o_ctrl,
  output logic [`DATA_W-1:0]         o_word_data,
  output logic                       o_word_wr,     // One-cycle pulse
  output logic                       o_mem_rd_req,
  output logic [7:0]                 o_spi_rd_byte
);

  import loader_pkg::*;

  cpu_ctrl_t  ctrl_q;
  logic [7:0] byte_q [0:1];  // Byte pair, index is address bit 0
  logic       spi_wr_q;      // Write level of the previous cycle
  logic       ctrl_sel;
  logic       mem_sel;

  assign ctrl_sel = (i_spi_addr[`SPI_ADDR_W-1 -: 8] == `CTRL_PAGE);
  assign mem_sel  = (i_spi_addr[`SPI_ADDR_W-1 -: 8] == `MEM_PAGE);

  // ============================================================
  // Control register and write pulse
  // ============================================================
  always_ff @(posedge clk_cpu)
  begin
    if (i_reset)
    begin
      ctrl_q.raw <= `CTRL_RESET_VAL;  // Start halted
      spi_wr_q   <= 1'b0;
      o_word_wr  <= 1'b0;
    end
    else
    begin
      spi_wr_q <= i_spi_wr;
      if (i_spi_wr && ctrl_sel)
        ctrl_q.raw <= i_spi_data;
      // Rising edge of write level on the odd memory byte
      o_word_wr <= i_spi_wr && !spi_wr_q && mem_sel && i_spi_addr[0];
    end
  end

  // Byte buffer, payload only
  always_ff @(posedge clk_cpu)
  begin
    if (i_spi_wr && !ctrl_sel)
      byte_q[i_spi_addr[0]] <= i_spi_data;
  end

  assign o_ctrl      = ctrl_q;
  assign o_word_data = {byte_q[0], byte_q[1]};  // Even byte on top, big endian

  // Read path
  assign o_mem_rd_req  = i_spi_rd && mem_sel;
  assign o_spi_rd_byte = i_spi_addr[0] ? i_mem_dout[7:0] : i_mem_dout[15:8];

endmodule

`default_nettype wire

// ==== design/mem_port_mux.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "m68k_glue_defines.svh"

module mem_port_mux
(
  input  wire loader_pkg::cpu_ctrl_t i_ctrl,
  input  wire [`ADDR_W:1]            i_cpu_addr,
  input  wire [`DATA_W-1:0]          i_cpu_dout,
  input  wire                        i_cpu_rw,      // 1 read, 0 write
  input  wire                        i_cpu_as_n,
  input  wire                        i_cpu_uds_n,
  input  wire                        i_cpu_lds_n,
  input  wire [`SPI_ADDR_W-1:0]      i_spi_addr,
  input  wire [`DATA_W-1:0]          i_word_data,
  input  wire                        i_word_wr,
  input  wire                        i_mem_rd_req,
  output logic [`ADDR_W:1]           o_mem_addr,
  output logic [`DATA_W-1:0]         o_mem_din,
  output logic                       o_mem_as_n,
  output logic                       o_mem_uds_n,
  output logic                       o_mem_lds_n,
  output logic                       o_mem_rw
);

  logic loader_owns;
  logic ldr_strobe_n;  // All strobes for a loader access

  assign loader_owns  = i_ctrl.f.loader_owns_mem;
  assign ldr_strobe_n = ~(i_word_wr | i_mem_rd_req);

  // Loader accesses whole words
  assign o_mem_addr  = loader_owns ? i_spi_addr[`ADDR_W:1] : i_cpu_addr;
  assign o_mem_din   = loader_owns ? i_word_data : i_cpu_dout;
  assign o_mem_as_n  = loader_owns ? ldr_strobe_n : i_cpu_as_n;
  assign o_mem_uds_n = loader_owns ? ldr_strobe_n : i_cpu_uds_n;
  assign o_mem_lds_n = loader_owns ? ldr_strobe_n : i_cpu_lds_n;
  assign o_mem_rw    = loader_owns ? ~i_word_wr : i_cpu_rw;  // Write only on pulse

endmodule

`default_nettype wire

// ==== design/m68k_glue_top.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "m68k_glue_defines.svh"

module m68k_glue_top
(
  input  wire                   clk_cpu,
  input  wire                   i_reset,
  // CPU bus
  input  wire [`ADDR_W:1]       i_cpu_addr,
  input  wire [`DATA_W-1:0]     i_cpu_dout,
  input  wire                   i_cpu_rw,
  input  wire                   i_cpu_as_n,
  input  wire                   i_cpu_uds_n,
  input  wire                   i_cpu_lds_n,
  input  wire                   i_cpu_vma_n,
  // Peripheral and memory data
  input  wire [7:0]             i_acia_dout,
  input  wire [63:0]            i_kbd_matrix,
  input  wire [`DATA_W-1:0]     i_mem_dout,
  input  wire                   i_btn_reset_n,
  // SPI loader
  input  wire                   i_spi_wr,
  input  wire                   i_spi_rd,
  input  wire [`SPI_ADDR_W-1:0] i_spi_addr,
  input  wire [7:0]             i_spi_data,
  // Timing
  output logic                  o_phi1,
  output logic                  o_phi2,
  output logic                  o_baud_clk,
  // CPU control and selects
  output logic                  o_vpa_n,
  output logic                  o_acia_cs,
  output logic                  o_kbd_cs,
  output logic                  o_cpu_halt_n,
  output logic                  o_cpu_ext_reset,
  output logic                  o_cpu_pwr_up,
  output logic [`DATA_W-1:0]    o_cpu_din,
  // Loader
  output logic [`DATA_W-1:0]    o_word_data,
  output logic                  o_word_wr,
  output logic                  o_mem_rd_req,
  output logic [7:0]            o_spi_rd_byte,
  // External memory port
  output logic [`ADDR_W:1]      o_mem_addr,
  output logic [`DATA_W-1:0]    o_mem_din,
  output logic                  o_mem_as_n,
  output logic                  o_mem_uds_n,
  output logic                  o_mem_lds_n,
  output logic                  o_mem_rw
);

  import bus_pkg::*;
  import loader_pkg::*;

  logic       pwr_up;  // Power-up stretch
  cpu_ctrl_t  ctrl;    // Loader control byte
  rd_source_t rd_src;

  timing_gen timing_gen_inst
  (
    .clk_cpu    (clk_cpu),
    .i_reset    (i_reset),
    .o_phi1     (o_phi1),
    .o_phi2     (o_phi2),
    .o_baud_clk (o_baud_clk),
    .o_pwr_up   (pwr_up)
  );

  bus_control bus_control_inst
  (
    .i_cpu_addr      (i_cpu_addr),
    .i_cpu_as_n      (i_cpu_as_n),
    .i_cpu_vma_n     (i_cpu_vma_n),
    .i_btn_reset_n   (i_btn_reset_n),
    .i_pwr_up        (pwr_up),
    .i_ctrl          (ctrl),
    .o_vpa_n         (o_vpa_n),
    .o_acia_cs       (o_acia_cs),
    .o_kbd_cs        (o_kbd_cs),
    .o_rd_src        (rd_src),
    .o_cpu_halt_n    (o_cpu_halt_n),
    .o_cpu_ext_reset (o_cpu_ext_reset),
    .o_cpu_pwr_up    (o_cpu_pwr_up)
  );

  read_data_mux read_data_mux_inst
  (
    .i_rd_src     (rd_src),
    .i_cpu_addr   (i_cpu_addr),
    .i_acia_dout  (i_acia_dout),
    .i_kbd_matrix (i_kbd_matrix),
    .i_mem_dout   (i_mem_dout),
    .o_cpu_din    (o_cpu_din)
  );

  loader_regs loader_regs_inst
  (
    .clk_cpu       (clk_cpu),
    .i_reset       (i_reset),
    .i_spi_wr      (i_spi_wr),
    .i_spi_rd      (i_spi_rd),
    .i_spi_addr    (i_spi_addr),
    .i_spi_data    (i_spi_data),
    .i_mem_dout    (i_mem_dout),
    .o_ctrl        (ctrl),
    .o_word_data   (o_word_data),
    .o_word_wr     (o_word_wr),
    .o_mem_rd_req  (o_mem_rd_req),
    .o_spi_rd_byte (o_spi_rd_byte)
  );

  mem_port_mux mem_port_mux_inst
  (
    .i_ctrl       (ctrl),
    .i_cpu_addr   (i_cpu_addr),
    .i_cpu_dout   (i_cpu_dout),
    .i_cpu_rw     (i_cpu_rw),
    .i_cpu_as_n   (i_cpu_as_n),
    .i_cpu_uds_n  (i_cpu_uds_n),
    .i_cpu_lds_n  (i_cpu_lds_n),
    .i_spi_addr   (i_spi_addr),
    .i_word_data  (o_word_data),
    .i_word_wr    (o_word_wr),
    .i_mem_rd_req (o_mem_rd_req),
    .o_mem_addr   (o_mem_addr),
    .o_mem_din    (o_mem_din),
    .o_mem_as_n   (o_mem_as_n),
    .o_mem_uds_n  (o_mem_uds_n),
    .o_mem_lds_n  (o_mem_lds_n),
    .o_mem_rw     (o_mem_rw)
  );

endmodule

`default_nettype wire

// ==== verification/m68k_glue_checker.sv ====
`default_nettype none
`timescale 1ns/10ps

module m68k_glue_checker
#(
  parameter bit PHASE_CHECKS = 1'b0,  // Phase enable rules
  parameter bit PULSE_CHECKS = 1'b0   // Word write pulse rule
)
(
  input wire clk_cpu,
  input wire i_reset,
  input wire i_phi1,
  input wire i_phi2,
  input wire i_word_wr
);

  int fail_count = 0;  // Failed assertions so far

  // ============================================================
  // Phase enables
  // ============================================================
  generate
    if (PHASE_CHECKS)
    begin : g_phase
      // phi2 is phi1 delayed by one cycle
      phi2_follows_phi1: assert property (@(posedge clk_cpu) disable iff (i_reset)
        i_phi2 == $past(i_phi1))
      else
      begin
        fail_count++;
        $error("phi2 is not the previous phi1");
      end

      // Toggle every cycle once out of reset
      phi1_toggles: assert property (@(posedge clk_cpu) disable iff (i_reset)
        !$past(i_reset) |-> (i_phi1 != $past(i_phi1)))
      else
      begin
        fail_count++;
        $error("phi1 did not invert");
      end
    end
  endgenerate

  // Single cycle word write
  generate
    if (PULSE_CHECKS)
    begin : g_pulse
      word_wr_single: assert property (@(posedge clk_cpu) disable iff (i_reset)
        i_word_wr |=> !i_word_wr)
      else
      begin
        fail_count++;
        $error("word write held for two cycles");
      end
    end
  endgenerate

endmodule

bind timing_gen m68k_glue_checker #(.PHASE_CHECKS(1'b1)) phase_checker
(
  .clk_cpu   (clk_cpu),
  .i_reset   (i_reset),
  .i_phi1    (o_phi1),
  .i_phi2    (o_phi2),
  .i_word_wr (1'b0)
);

bind loader_regs m68k_glue_checker #(.PULSE_CHECKS(1'b1)) pulse_checker
(
  .clk_cpu   (clk_cpu),
  .i_reset   (i_reset),
  .i_phi1    (1'b0),
  .i_phi2    (1'b0),
  .i_word_wr (o_word_wr)
);

`default_nettype wire

// ==== verification/m68k_glue_tb.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "m68k_glue_defines.svh"

module m68k_glue_tb;

  localparam logic [1:0] K_LWR = 2'd0;  // Loader write
  localparam logic [1:0] K_LRD = 2'd1;  // Loader read-back
  localparam logic [1:0] K_CPU = 2'd2;  // CPU read cycle
  localparam int N_STEPS     = 15;
  localparam int PWRUP_LIMIT = 70000;  // Cycles beyond the 2^16-1 stretch
  localparam int BAUD_LIMIT  = 400;

  logic                   clk_cpu;
  logic                   i_reset;
  logic [`ADDR_W:1]       i_cpu_addr;
  logic [`DATA_W-1:0]     i_cpu_dout;
  logic                   i_cpu_rw;
  logic                   i_cpu_as_n;
  logic                   i_cpu_uds_n;
  logic                   i_cpu_lds_n;
  logic                   i_cpu_vma_n;
  logic [7:0]             i_acia_dout;
  logic [63:0]            i_kbd_matrix;
  logic [`DATA_W-1:0]     i_mem_dout;
  logic                   i_btn_reset_n;
  logic                   i_spi_wr;
  logic                   i_spi_rd;
  logic [`SPI_ADDR_W-1:0] i_spi_addr;
  logic [7:0]             i_spi_data;
  logic                   o_phi1;
  logic                   o_phi2;
  logic                   o_baud_clk;
  logic                   o_vpa_n;
  logic                   o_acia_cs;
  logic                   o_kbd_cs;
  logic                   o_cpu_halt_n;
  logic                   o_cpu_ext_reset;
  logic                   o_cpu_pwr_up;
  logic [`DATA_W-1:0]     o_cpu_din;
  logic [`DATA_W-1:0]     o_word_data;
  logic                   o_word_wr;
  logic                   o_mem_rd_req;
  logic [7:0]             o_spi_rd_byte;
  logic [`ADDR_W:1]       o_mem_addr;
  logic [`DATA_W-1:0]     o_mem_din;
  logic                   o_mem_as_n;
  logic                   o_mem_uds_n;
  logic                   o_mem_lds_n;
  logic                   o_mem_rw;

  // ============================================================
  // Stimulus table
  // ============================================================
  // Control page writes expect {halt_n, ext_reset, mem AS with CPU AS low}
  // Memory page writes expect the word at the pulse of odd addresses
  // CPU reads take {vma_n, as_n} as data and expect {source, vpa_n}
  // Source codes 0 mem 1 UART 2 keys
  logic [1:0]  tbl_kind [N_STEPS];
  logic [31:0] tbl_addr [N_STEPS];
  logic [7:0]  tbl_data [N_STEPS];
  logic [15:0] tbl_exp  [N_STEPS];
  int          tbl_count = 0;

  integer seed = 32'hf591;
  int     checks = 0;
  int     mismatches = 0;
  int     timeouts = 0;

  m68k_glue_top m68k_glue_top_inst (.*);

  initial
  begin
    clk_cpu = 1'b0;
    forever #5 clk_cpu = ~clk_cpu;  // 100 MHz
  end

  task automatic compare_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
    checks++;
    assert (got == want)
    else
    begin
      mismatches++;
      $display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic add_step(input logic [1:0] kind, input logic [31:0] addr,
                          input logic [7:0] data, input logic [15:0] want);
    tbl_kind[tbl_count] = kind;
    tbl_addr[tbl_count] = addr;
    tbl_data[tbl_count] = data;
    tbl_exp[tbl_count]  = want;
    tbl_count++;
  endtask

  // Fresh memory, UART and key matrix values
  task automatic draw_random_inputs();
    logic [31:0] r;
    r = $random(seed);
    i_mem_dout = r[15:0];
    r = $random(seed);
    i_acia_dout = r[7:0];
    r = $random(seed);
    i_kbd_matrix[31:0] = r;
    r = $random(seed);
    i_kbd_matrix[63:32] = r;
  endtask

  task automatic write_ctrl(input logic [31:0] addr, input logic [7:0] data,
                            input logic [2:0] want);
    i_spi_addr = addr;
    i_spi_data = data;
    i_spi_wr   = 1'b1;
    @(negedge clk_cpu);
    i_spi_wr   = 1'b0;
    i_cpu_as_n = 1'b0;  // Shows up on memory AS only if CPU owns it
    #1;
    compare_value(32'(o_cpu_halt_n), 32'(want[2]), "halt_n after control write");
    compare_value(32'(o_cpu_ext_reset), 32'(want[1]), "ext_reset after control write");
    compare_value(32'(o_mem_as_n), 32'(want[0]), "memory AS with CPU AS low");
    @(negedge clk_cpu);
    i_cpu_as_n = 1'b1;
  endtask

  task automatic write_byte(input logic [31:0] addr, input logic [7:0] data,
                            input logic [15:0] want);
    int pulses;
    int n;
    pulses     = 0;
    i_spi_addr = addr;
    i_spi_data = data;
    i_spi_wr   = 1'b1;
    for (n = 0; n < 5; n++)  // Level held 3 cycles and then idle
    begin
      @(negedge clk_cpu);
      if (n == 2)
        i_spi_wr = 1'b0;
      #1;
      if (o_word_wr)
      begin
        pulses++;
        compare_value(32'(o_word_data), 32'(want), "assembled word at write pulse");
        compare_value(32'(o_mem_din), 32'(want), "word data at write pulse");
        compare_value(32'(o_mem_addr), 32'(addr[23:1]), "memory address at write pulse");
        compare_value(32'(o_mem_rw), 32'd0, "memory rw at write pulse");
        compare_value(32'({o_mem_as_n, o_mem_uds_n, o_mem_lds_n}), 32'd0,
                      "memory strobes at write pulse");
      end
    end
    compare_value(32'(pulses), 32'(addr[0]), "word write pulse count");
  endtask

  // High byte for even address and low byte for odd
  task automatic read_back(input logic [31:0] addr);
    draw_random_inputs();
    i_spi_addr = addr;
    i_spi_rd   = 1'b1;
    #1;
    compare_value(32'(o_spi_rd_byte), 32'(addr[0] ? i_mem_dout[7:0] : i_mem_dout[15:8]),
                  "loader read-back byte");
    compare_value(32'(o_mem_rd_req), 32'd1, "memory read request");
    @(negedge clk_cpu);
    i_spi_rd = 1'b0;
  endtask

  task automatic cpu_read(input logic [31:0] addr, input logic [1:0] ctl,
                          input logic [2:0] want);
    logic [15:0] din;
    logic [63:0] shifted;
    draw_random_inputs();
    i_cpu_addr  = addr[23:1];
    i_cpu_as_n  = ctl[0];
    i_cpu_vma_n = ctl[1];
    shifted = i_kbd_matrix >> {addr[6:4], 3'b000};  // Byte N at bit 8N
    case (want[2:1])
      2'd1:    din = {8'd0, i_acia_dout};
      2'd2:    din = {8'd0, shifted[7:0]};
      default: din = i_mem_dout;
    endcase
    #1;
    compare_value(32'(o_vpa_n), 32'(want[0]), "VPA for CPU address");
    compare_value(32'(o_acia_cs), 32'(want[2:1] == 2'd1), "UART select");
    compare_value(32'(o_kbd_cs), 32'(want[2:1] == 2'd2), "keyboard select");
    compare_value(32'(o_cpu_din), 32'(din), "CPU read data");
    @(negedge clk_cpu);
    i_cpu_as_n  = 1'b1;
    i_cpu_vma_n = 1'b1;
  endtask

  task automatic apply_step(input int idx);
    @(negedge clk_cpu);
    case (tbl_kind[idx])
      K_LWR:
        if (tbl_addr[idx][31:24] == `CTRL_PAGE)
          write_ctrl(tbl_addr[idx], tbl_data[idx], tbl_exp[idx][2:0]);
        else
          write_byte(tbl_addr[idx], tbl_data[idx], tbl_exp[idx]);
      K_LRD:   read_back(tbl_addr[idx]);
      default: cpu_read(tbl_addr[idx], tbl_data[idx][1:0], tbl_exp[idx][2:0]);
    endcase
  endtask

  // Period and high time between rising edges
  task automatic measure_baud();
    int   n;
    int   period;
    int   high;
    logic prev;
    logic rose;
    prev = 1'b1;  // Skip a clock already high
    rose = 1'b0;
    for (n = 0; n < BAUD_LIMIT && !rose; n++)
    begin
      @(negedge clk_cpu);
      rose = o_baud_clk && !prev;
      prev = o_baud_clk;
    end
    if (!rose)
    begin
      timeouts++;
      $display("Timeout: baud clock did not rise within %0d cycles", BAUD_LIMIT);
    end
    period = 0;
    high   = 0;
    for (n = 0; n < BAUD_LIMIT && rose; n++)
    begin
      if (o_baud_clk)
        high++;
      period++;
      @(negedge clk_cpu);
      rose = !(o_baud_clk && !prev);  // Run until next rise
      prev = o_baud_clk;
    end
    if (rose)
    begin
      timeouts++;
      $display("Timeout: baud clock did not rise again within %0d cycles", BAUD_LIMIT);
    end
    compare_value(32'(period), 32'(`BAUD_TOP + 1), "baud clock period");
    compare_value(32'(high), 32'(`BAUD_TOP - `BAUD_HIGH_FROM), "baud clock high time");
  endtask

  initial
  begin
    int n;
    int asserts;
    i_reset = 1'b1;
    i_cpu_addr = '0;
    i_cpu_dout = '0;
    i_cpu_rw = 1'b1;
    i_cpu_as_n = 1'b1;
    i_cpu_uds_n = 1'b1;
    i_cpu_lds_n = 1'b1;
    i_cpu_vma_n = 1'b1;
    i_acia_dout = '0;
    i_kbd_matrix = '0;
    i_mem_dout = '0;
    i_btn_reset_n = 1'b1;  // Button released
    i_spi_wr = 1'b0;
    i_spi_rd = 1'b0;
    i_spi_addr = '0;
    i_spi_data = '0;

    add_step(K_LWR, 32'hFF00_0000, 8'h02, 16'h0005);  // Loader owns memory with halt off
    add_step(K_LWR, 32'h0000_0010, 8'hA5, 16'h0000);
    add_step(K_LWR, 32'h0000_0011, 8'h3C, 16'hA53C);
    add_step(K_LWR, 32'h0000_1234, 8'h7E, 16'h0000);
    add_step(K_LWR, 32'h0000_1235, 8'h81, 16'h7E81);
    add_step(K_LRD, 32'h0000_0010, 8'h00, 16'h0000);
    add_step(K_LRD, 32'h0000_0011, 8'h00, 16'h0000);
    add_step(K_LWR, 32'hFF00_0000, 8'h03, 16'h0007);  // CPU reset requested
    add_step(K_LWR, 32'hFF00_0000, 8'h00, 16'h0004);  // CPU owns memory again
    add_step(K_CPU, 32'h0060_0000, 8'h02, 16'h0000);  // Peripheral page without VMA
    add_step(K_CPU, 32'h0060_0000, 8'h00, 16'h0002);  // UART
    add_step(K_CPU, 32'h0060_0036, 8'h00, 16'h0004);  // Key byte 3
    add_step(K_CPU, 32'h0060_0076, 8'h00, 16'h0004);  // Key byte 7
    add_step(K_CPU, 32'h0040_000E, 8'h00, 16'h0001);  // Other page
    add_step(K_CPU, 32'h0060_0004, 8'h03, 16'h0001);  // AS high

    repeat (16) @(negedge clk_cpu);
    i_reset = 1'b0;
    #1;
    compare_value(32'(o_cpu_halt_n), 32'd0, "halt_n after reset");
    compare_value(32'(o_cpu_ext_reset), 32'd1, "ext_reset after reset");
    compare_value(32'(o_cpu_pwr_up), 32'd1, "power-up flag after reset");

    // Power-up stretch
    for (n = 0; n < PWRUP_LIMIT && o_cpu_ext_reset; n++)
      @(negedge clk_cpu);
    if (o_cpu_ext_reset)
    begin
      timeouts++;
      $display("Timeout: CPU reset still active after %0d cycles", PWRUP_LIMIT);
    end
    compare_value(32'(o_cpu_pwr_up), 32'd0, "power-up flag after stretch");

    measure_baud();

    for (n = 0; n < tbl_count; n++)
      apply_step(n);

    @(negedge clk_cpu);
    asserts = m68k_glue_top_inst.timing_gen_inst.phase_checker.fail_count
            + m68k_glue_top_inst.loader_regs_inst.pulse_checker.fail_count;
    $display("Checks: %0d, mismatches: %0d, timeouts: %0d, assertion failures: %0d",
             checks, mismatches, timeouts, asserts);
    if (mismatches + timeouts + asserts == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+design
design/bus_pkg.sv
design/loader_pkg.sv
design/timing_gen.sv
design/bus_control.sv
design/read_data_mux.sv
design/loader_regs.sv
design/mem_port_mux.sv
design/m68k_glue_top.sv
verification/m68k_glue_checker.sv
verification/m68k_glue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator, run, and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module m68k_glue_tb -f all.f -o m68k_glue_sim

out=$(./obj_dir/m68k_glue_sim +verilator+error+limit+1000)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1
